// ==== logic/arrow_mask_unit.sv ====
`timescale 1ns/1ps

module arrow_mask_unit
    import geometry_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_in,
    hit_if.sink   hit,
    output logic  arrow_mask,
    output logic  mask_valid
);

    // hit relative to block, wraps like the hardware adders
    fix_t rel_x;
    fix_t rel_y;
    fix_t rel_z;

    // stage 1
    fix_t       dx;
    fix_t       dy;
    fix_t       dz;
    fix_t       sum_xy;
    fix_t       diff_yx;
    arrow_dir_t dir_s1;
    logic       valid_s1;

    // stage 2 decode
    logic on_top;
    logic in_bounds;
    logic sum_neg;
    logic diff_neg;
    logic in_region;

    //////////////////////////////////////////////////////////////////////
    // stage 1: offsets from the top face center
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rel_x = hit.hit_x - hit.block_x;
        rel_y = hit.hit_y - hit.block_y;
        rel_z = hit.hit_z - hit.block_z - TOP_FACE_OFFSET;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            dx       <= '0;
            dy       <= '0;
            dz       <= '0;
            sum_xy   <= '0;
            diff_yx  <= '0;
            dir_s1   <= UP;
            valid_s1 <= 1'b0;
        end else begin
            dx       <= rel_x;
            dy       <= rel_y;
            dz       <= rel_z;
            sum_xy   <= rel_x + rel_y;
            diff_yx  <= rel_y - rel_x;
            dir_s1   <= hit.dir;
            valid_s1 <= hit.valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: face, bounds and triangle tests
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        on_top    = (dz <= FACE_EPS);
        in_bounds = (dx > -ARROW_HALF_SPAN) && (dx < ARROW_HALF_SPAN) &&
                    (dy > -ARROW_HALF_SPAN) && (dy < ARROW_HALF_SPAN);
        sum_neg   = sum_xy[31];
        diff_neg  = diff_yx[31];

        // the two diagonals split the square into four triangles
        case (dir_s1)
            UP:      in_region = sum_neg && diff_neg;
            RIGHT:   in_region = !sum_neg && diff_neg;
            DOWN:    in_region = !sum_neg && !diff_neg;
            default: in_region = sum_neg && !diff_neg;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            arrow_mask <= 1'b0;
            mask_valid <= 1'b0;
        end else begin
            arrow_mask <= on_top && in_bounds && in_region;
            mask_valid <= valid_s1;
        end
    end

endmodule

// ==== logic/geometry_pkg.sv ====
package geometry_pkg;

    //////////////////////////////////////////////////////////////////////
    // fixed point format
    //////////////////////////////////////////////////////////////////////

    // signed Q16.16
    typedef logic signed [31:0] fix_t;

    localparam int FRAC_BITS = 16;

    // full width product, back to Q16.16, wraps on overflow
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[FRAC_BITS +: 32];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // scene geometry
    //////////////////////////////////////////////////////////////////////

    // eye position
    localparam fix_t EYE_X = fix_t'(1800 <<< FRAC_BITS);
    localparam fix_t EYE_Y = fix_t'(1800 <<< FRAC_BITS);
    localparam fix_t EYE_Z = fix_t'(-300 <<< FRAC_BITS);

    // top face sits this far above the block origin
    localparam fix_t TOP_FACE_OFFSET = fix_t'(200 <<< FRAC_BITS);
    localparam fix_t ARROW_HALF_SPAN = fix_t'(80 <<< FRAC_BITS);

    // about 0.01
    localparam fix_t FACE_EPS = fix_t'(655);

    // codes 4..7 fall back to LEFT
    typedef enum logic [2:0] {
        UP    = 3'd0,
        RIGHT = 3'd1,
        DOWN  = 3'd2,
        LEFT  = 3'd3
    } arrow_dir_t;

endpackage

// ==== logic/hit_if.sv ====
`timescale 1ns/1ps

interface hit_if
    import geometry_pkg::*, lighting_pkg::*;
();

    logic       valid;
    fix_t       hit_x;
    fix_t       hit_y;
    fix_t       hit_z;
    fix_t       block_x;
    fix_t       block_y;
    fix_t       block_z;
    arrow_dir_t dir;
    rgb_t       mat;

    modport source (
        output valid, hit_x, hit_y, hit_z,
        output block_x, block_y, block_z, dir, mat
    );

    modport sink (
        input valid, hit_x, hit_y, hit_z,
        input block_x, block_y, block_z, dir, mat
    );

endinterface

// ==== logic/hit_point_unit.sv ====
`timescale 1ns/1ps

module hit_point_unit
    import geometry_pkg::*, lighting_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       valid_in,
    input  fix_t       ray_x,
    input  fix_t       ray_y,
    input  fix_t       ray_z,
    input  fix_t       t_in,
    input  fix_t       block_x,
    input  fix_t       block_y,
    input  fix_t       block_z,
    input  arrow_dir_t block_dir,
    input  rgb_t       mat,
    hit_if.source      hit
);

    // stage 1
    fix_t       scaled_x;
    fix_t       scaled_y;
    fix_t       scaled_z;
    logic       valid_s1;
    fix_t       block_x_s1;
    fix_t       block_y_s1;
    fix_t       block_z_s1;
    arrow_dir_t dir_s1;
    rgb_t       mat_s1;

    //////////////////////////////////////////////////////////////////////
    // stage 1: t times ray
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            scaled_x   <= '0;
            scaled_y   <= '0;
            scaled_z   <= '0;
            valid_s1   <= 1'b0;
            block_x_s1 <= '0;
            block_y_s1 <= '0;
            block_z_s1 <= '0;
            dir_s1     <= UP;
            mat_s1     <= '0;
        end else begin
            scaled_x   <= fix_mul(ray_x, t_in);
            scaled_y   <= fix_mul(ray_y, t_in);
            scaled_z   <= fix_mul(ray_z, t_in);
            valid_s1   <= valid_in;
            block_x_s1 <= block_x;
            block_y_s1 <= block_y;
            block_z_s1 <= block_z;
            dir_s1     <= block_dir;
            mat_s1     <= mat;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: add eye, block data leaves with the hit point
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            hit.valid   <= 1'b0;
            hit.hit_x   <= '0;
            hit.hit_y   <= '0;
            hit.hit_z   <= '0;
            hit.block_x <= '0;
            hit.block_y <= '0;
            hit.block_z <= '0;
            hit.dir     <= UP;
            hit.mat     <= '0;
        end else begin
            hit.valid   <= valid_s1;
            hit.hit_x   <= scaled_x + EYE_X;
            hit.hit_y   <= scaled_y + EYE_Y;
            hit.hit_z   <= scaled_z + EYE_Z;
            hit.block_x <= block_x_s1;
            hit.block_y <= block_y_s1;
            hit.block_z <= block_z_s1;
            hit.dir     <= dir_s1;
            hit.mat     <= mat_s1;
        end
    end

endmodule

// ==== logic/lighting_pkg.sv ====
package lighting_pkg;

    import geometry_pkg::*;

    localparam int NUM_LIGHTS = 3;

    // per light intensity, one word per channel
    // 0.25 = 16384, 0.5 = 32768, 0.75 = 49152
    localparam fix_t LIGHT_R [NUM_LIGHTS] = '{
        fix_t'(16384),
        fix_t'(32768),
        fix_t'(16384)
    };
    localparam fix_t LIGHT_G [NUM_LIGHTS] = '{
        fix_t'(49152),
        fix_t'(32768),
        fix_t'(49152)
    };
    localparam fix_t LIGHT_B [NUM_LIGHTS] = '{
        fix_t'(16384),
        fix_t'(32768),
        fix_t'(16384)
    };

    // color triple, also used for material
    typedef struct packed {
        fix_t r;
        fix_t g;
        fix_t b;
    } rgb_t;

endpackage

// ==== logic/pixel_color_top.sv ====
`timescale 1ns/1ps

module pixel_color_top
    import geometry_pkg::*, lighting_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       valid_in,
    input  fix_t       ray_x,
    input  fix_t       ray_y,
    input  fix_t       ray_z,
    input  fix_t       t_in,
    input  fix_t       block_x,
    input  fix_t       block_y,
    input  fix_t       block_z,
    input  logic [2:0] block_dir,
    input  fix_t       mat_r,
    input  fix_t       mat_g,
    input  fix_t       mat_b,
    output fix_t       r_out,
    output fix_t       g_out,
    output fix_t       b_out,
    output logic       rgb_valid
);

    rgb_t mat_in;
    logic arrow_mask;
    logic mask_valid;

    hit_if hit_bus ();

    assign mat_in = '{r: mat_r, g: mat_g, b: mat_b};

    ////////////////////////////////////////////////////////////////////
    // hit point, then mask and shading side by side
    ////////////////////////////////////////////////////////////////////

    hit_point_unit u_hit_point_unit (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .ray_x     (ray_x),
        .ray_y     (ray_y),
        .ray_z     (ray_z),
        .t_in      (t_in),
        .block_x   (block_x),
        .block_y   (block_y),
        .block_z   (block_z),
        .block_dir (arrow_dir_t'(block_dir)),
        .mat       (mat_in),
        .hit       (hit_bus.source)
    );

    arrow_mask_unit u_arrow_mask_unit (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .hit        (hit_bus.sink),
        .arrow_mask (arrow_mask),
        .mask_valid (mask_valid)
    );

    // mask lands as the light sums finish
    pixel_shade_unit u_pixel_shade_unit (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .hit        (hit_bus.sink),
        .arrow_mask (arrow_mask),
        .mask_valid (mask_valid),
        .r_out      (r_out),
        .g_out      (g_out),
        .b_out      (b_out),
        .rgb_valid  (rgb_valid)
    );

endmodule

// ==== logic/pixel_shade_unit.sv ====
`timescale 1ns/1ps

module pixel_shade_unit
    import geometry_pkg::*, lighting_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_in,
    hit_if.sink   hit,
    input  logic  arrow_mask,
    input  logic  mask_valid,
    output fix_t  r_out,
    output fix_t  g_out,
    output fix_t  b_out,
    output logic  rgb_valid
);

    // stage 1, one product per light and channel
    fix_t prod_r [NUM_LIGHTS];
    fix_t prod_g [NUM_LIGHTS];
    fix_t prod_b [NUM_LIGHTS];

    // stage 2
    rgb_t acc;
    rgb_t sum;

    fix_t max_rg;
    fix_t grey;

    //////////////////////////////////////////////////////////////////////
    // stage 1: intensity times material
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < NUM_LIGHTS; i++) begin
                prod_r[i] <= '0;
                prod_g[i] <= '0;
                prod_b[i] <= '0;
            end
        end else if (hit.valid) begin
            for (int i = 0; i < NUM_LIGHTS; i++) begin
                prod_r[i] <= fix_mul(LIGHT_R[i], hit.mat.r);
                prod_g[i] <= fix_mul(LIGHT_G[i], hit.mat.g);
                prod_b[i] <= fix_mul(LIGHT_B[i], hit.mat.b);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: sum over lights
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        acc = '0;
        for (int i = 0; i < NUM_LIGHTS; i++) begin
            acc.r = acc.r + prod_r[i];
            acc.g = acc.g + prod_g[i];
            acc.b = acc.b + prod_b[i];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sum <= '0;
        end else begin
            sum <= acc;
        end
    end

    // grey level is the brightest channel, signed compare
    always_comb begin
        max_rg = (sum.r > sum.g) ? sum.r : sum.g;
        grey   = (max_rg > sum.b) ? max_rg : sum.b;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            r_out     <= '0;
            g_out     <= '0;
            b_out     <= '0;
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= mask_valid;
            if (mask_valid) begin
                r_out <= arrow_mask ? grey : sum.r;
                g_out <= arrow_mask ? grey : sum.g;
                b_out <= arrow_mask ? grey : sum.b;
            end
        end
    end

endmodule

// ==== pixel_color.f ====
+incdir+include
logic/geometry_pkg.sv
logic/lighting_pkg.sv
logic/hit_if.sv
logic/hit_point_unit.sv
logic/arrow_mask_unit.sv
logic/pixel_shade_unit.sv
logic/pixel_color_top.sv
verification/pixel_color_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pixel color testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module pixel_color_tb \
    -f pixel_color.f -o pixel_color_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/pixel_color_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log

grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== include/pixel_color_model.svh ====
`ifndef PIXEL_COLOR_MODEL_SVH
`define PIXEL_COLOR_MODEL_SVH

// needs geometry_pkg and lighting_pkg imported by the including module

// Q16.16 product truncated to one word
function automatic fix_t fixed_mul(input fix_t a, input fix_t b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return fix_t'(prod >>> FRAC_BITS);
endfunction

// eye plus t times ray on one axis
function automatic fix_t hit_coord(input fix_t ray, input fix_t t, input fix_t eye);
    return fixed_mul(ray, t) + eye;
endfunction

function automatic bit arrow_hit(input fix_t hx, input fix_t hy, input fix_t hz,
                                 input fix_t bx, input fix_t by, input fix_t bz,
                                 input logic [2:0] dir);
    fix_t dx;
    fix_t dy;
    fix_t dz;
    fix_t s;
    fix_t d;
    bit   region;
    dx = hx - bx;
    dy = hy - by;
    dz = hz - bz - TOP_FACE_OFFSET;
    s  = dx + dy;
    d  = dy - dx;
    case (dir)
        3'd0:    region = (s < 0) && (d < 0);
        3'd1:    region = (s >= 0) && (d < 0);
        3'd2:    region = (s >= 0) && (d >= 0);
        default: region = (s < 0) && (d >= 0);
    endcase
    return (dz <= FACE_EPS) && (dx > -ARROW_HALF_SPAN) && (dx < ARROW_HALF_SPAN) &&
           (dy > -ARROW_HALF_SPAN) && (dy < ARROW_HALF_SPAN) && region;
endfunction

function automatic rgb_t expected_color(input rgb_t mat, input bit mask);
    rgb_t sum;
    fix_t top;
    sum = '0;
    for (int i = 0; i < NUM_LIGHTS; i++) begin
        sum.r = sum.r + fixed_mul(LIGHT_R[i], mat.r);
        sum.g = sum.g + fixed_mul(LIGHT_G[i], mat.g);
        sum.b = sum.b + fixed_mul(LIGHT_B[i], mat.b);
    end
    top = (sum.r > sum.g) ? sum.r : sum.g;
    top = (top > sum.b) ? top : sum.b;
    if (mask) begin
        sum.r = top;
        sum.g = top;
        sum.b = top;
    end
    return sum;
endfunction

`endif

// ==== verification/pixel_color_tb.sv ====
`timescale 1ns/1ps

module pixel_color_tb
    import geometry_pkg::*, lighting_pkg::*;
();

    `include "pixel_color_model.svh"

    localparam int LATENCY    = 5;
    localparam int DRAIN_WAIT = 40;

    logic       clk_in;
    logic       rst_in;
    logic       valid_in;
    fix_t       ray_x, ray_y, ray_z, t_in;
    fix_t       block_x, block_y, block_z;
    logic [2:0] block_dir;
    fix_t       mat_r, mat_g, mat_b;
    fix_t       r_out, g_out, b_out;
    logic       rgb_valid;

    // expected color and the cycle it is due in
    rgb_t exp_color_q [$];
    int   exp_cycle_q [$];
    rgb_t exp_color;
    int   exp_cycle;

    logic [31:0] lcg_state;
    int cycle_cnt = 0;
    int value_errors = 0;
    int other_errors = 0;
    int sent_cnt = 0;
    int seen_cnt = 0;
    int arrow_cnt = 0;

    pixel_color_top u_pixel_color_top (.*);

    initial begin
        clk_in = 1'b0;
        forever begin
            #10 clk_in = 1'b1;
            #10 clk_in = 1'b0;
        end
    end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic flag_problem(input string msg);
        other_errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #2;
    endtask

    //////////////////////////////////////////////////////////////////////
    // aimed samples land near the top face
    //////////////////////////////////////////////////////////////////////

    task automatic send_sample(input bit aimed);
        logic [31:0] r;
        fix_t        hx, hy, hz, dz;
        bit          mask;
        r = lcg_next();
        block_x = fix_t'({6'd0, r[31:22], 16'd0});
        r = lcg_next();
        block_y = fix_t'({6'd0, r[31:22], 16'd0});
        r = lcg_next();
        block_z = fix_t'({6'd0, r[31:22], 16'd0});
        block_dir = r[21:19];
        if (aimed) begin
            // offsets of about +-100 around the face center
            r = lcg_next();
            hx = block_x + fix_t'(r % 32'd13107200) - fix_t'(32'd6553600);
            r = lcg_next();
            hy = block_y + fix_t'(r % 32'd13107200) - fix_t'(32'd6553600);
            r = lcg_next();
            case (r[31:30])
                2'd0:    dz = '0;
                2'd1:    dz = fix_t'(r % 32'd2621) - FACE_EPS;
                2'd2:    dz = FACE_EPS + fix_t'({31'd0, r[29]});
                default: dz = fix_t'({{8{r[29]}}, r[29:6]});
            endcase
            hz = block_z + TOP_FACE_OFFSET + dz;
            t_in  = fix_t'(32'h0001_0000);
            ray_x = hx - EYE_X;
            ray_y = hy - EYE_Y;
            ray_z = hz - EYE_Z;
        end else begin
            r = lcg_next();
            t_in = fix_t'({15'd0, r[31:15]});
            r = lcg_next();
            ray_x = fix_t'({{8{r[31]}}, r[31:8]});
            r = lcg_next();
            ray_y = fix_t'({{8{r[31]}}, r[31:8]});
            r = lcg_next();
            ray_z = fix_t'({{8{r[31]}}, r[31:8]});
        end
        r = lcg_next();
        mat_r = fix_t'({16'd0, r[31:16]});
        r = lcg_next();
        mat_g = fix_t'({16'd0, r[31:16]});
        r = lcg_next();
        mat_b = fix_t'({16'd0, r[31:16]});

        hx = hit_coord(ray_x, t_in, EYE_X);
        hy = hit_coord(ray_y, t_in, EYE_Y);
        hz = hit_coord(ray_z, t_in, EYE_Z);
        mask = arrow_hit(hx, hy, hz, block_x, block_y, block_z, block_dir);
        exp_color_q.push_back(expected_color('{r: mat_r, g: mat_g, b: mat_b}, mask));
        exp_cycle_q.push_back(cycle_cnt + LATENCY);
        valid_in = 1'b1;
        sent_cnt++;
        if (mask) begin
            arrow_cnt++;
        end
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk_in) begin
        if (rgb_valid) begin
            if (rst_in) begin
                flag_problem("rgb_valid went high during reset");
            end else if (exp_color_q.size() == 0) begin
                seen_cnt++;
                flag_problem("rgb_valid went high with no sample in flight");
            end else begin
                exp_color = exp_color_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                seen_cnt++;
                check_value("result cycle", cycle_cnt, exp_cycle);
                check_value("r_out", r_out, exp_color.r);
                check_value("g_out", g_out, exp_color.g);
                check_value("b_out", b_out, exp_color.b);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          waited;
        lcg_state = 32'd5232;
        rst_in    = 1'b1;
        valid_in  = 1'b0;
        ray_x     = '0;
        ray_y     = '0;
        ray_z     = '0;
        t_in      = '0;
        block_x   = '0;
        block_y   = '0;
        block_z   = '0;
        block_dir = '0;
        mat_r     = '0;
        mat_g     = '0;
        mat_b     = '0;
        repeat (16) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
        // nothing may come out while idle after reset
        repeat (8) next_cycle();

        // back to back samples
        for (int i = 0; i < 200; i++) begin
            send_sample(i % 2 == 0);
            next_cycle();
        end

        // random gaps in valid_in
        for (int i = 0; i < 120; i++) begin
            r = lcg_next();
            if (r[31:30] == 2'd0) begin
                valid_in = 1'b0;
            end else begin
                send_sample(r[29]);
            end
            next_cycle();
        end
        valid_in = 1'b0;

        waited = 0;
        while (exp_color_q.size() != 0 && waited < DRAIN_WAIT) begin
            next_cycle();
            waited++;
        end
        if (exp_color_q.size() != 0) begin
            flag_problem($sformatf("timed out with %0d results never seen",
                                   exp_color_q.size()));
        end
        repeat (LATENCY + 2) next_cycle();
        check_value("result count", seen_cnt, sent_cnt);

        $display("%0d results, %0d on the arrow, %0d value errors, %0d other errors",
                 seen_cnt, arrow_cnt, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
